//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// boot rom entry in kseg1
`define FETCH_RESET_VECTOR 32'hbfc0_0000

// address and instruction word width
`define FETCH_XLEN 32

// width of the fetch exception code
`define FETCH_EXC_W 2

`endif

//--- design/fetch_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

	// exceptions raised at fetch
	typedef enum logic [`FETCH_EXC_W-1:0] {
		EXC_NONE = 'd0,
		EXC_ADEL = 'd1		// address error on instruction load
	} fetch_exc_e;

	// primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,	// R-type, funct decides
		OP_J       = 6'h02,
		OP_JAL     = 6'h03
	} fetch_op_e;

	// one fetched instruction travelling down the front end
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] pc;
		logic [`FETCH_XLEN-1:0] inst;
		fetch_exc_e             exc;
		logic                   inslot;	// sits in a branch delay slot
	} fetch_item_t;

endpackage

`default_nettype wire

//--- design/fetch_item_if.sv
`timescale 1ns/1ps
`default_nettype none

// one fetched item per cycle between two front end stages
interface fetch_item_if;
	import fetch_pkg::*;

	logic        valid;	// item holds a real fetch
	fetch_item_t item;

	modport source (
		output valid,
		output item
	);

	modport sink (
		input valid,
		input item
	);

endinterface

`default_nettype wire

//--- design/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_gen (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,		// level from controller
	input  logic                   flush_i,		// pulse from controller
	input  logic [`FETCH_XLEN-1:0] flush_pc_i,
	input  logic                   jump_i,		// from jump_decode
	input  logic [`FETCH_XLEN-1:0] jump_pc_i,
	output logic                   inst_sram_en_o,
	output logic [`FETCH_XLEN-1:0] inst_sram_addr_o,
	output logic                   issue_o,		// read sent this cycle
	output logic [`FETCH_XLEN-1:0] issue_pc_o
);

	localparam logic [`FETCH_XLEN-1:0] PC_STEP = 4;

	logic [`FETCH_XLEN-1:0] pc_q;
	logic                   started_q;	// pc_q holds an address worth fetching
	logic                   req;

	// nothing goes out while frozen or while the address is being replaced
	assign req = started_q & ~stall_i & ~flush_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q      <= `FETCH_RESET_VECTOR;
			started_q <= 1'b0;
		end else if (flush_i) begin
			pc_q      <= flush_pc_i;	// flush beats everything
			started_q <= 1'b1;
		end else if (stall_i) begin
			pc_q <= pc_q;
		end else if (!started_q) begin
			// first cycle out of reset, vector not sent yet
			started_q <= 1'b1;
		end else if (jump_i) begin
			pc_q <= jump_pc_i;	// delay slot goes out this cycle
		end else begin
			pc_q <= pc_q + PC_STEP;
		end
	end

	// request straight from the register
	assign inst_sram_en_o   = req;
	assign inst_sram_addr_o = pc_q;

	// tell if_stage which address is in the sram
	assign issue_o    = req;
	assign issue_pc_o = pc_q;

endmodule

`default_nettype wire

//--- design/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module if_stage (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  logic                   flush_i,
	input  logic                   issue_i,		// pc_gen sent a read
	input  logic [`FETCH_XLEN-1:0] issue_pc_i,
	input  logic [`FETCH_XLEN-1:0] inst_sram_rdata_i,
	fetch_item_if.source           item_o
);
	import fetch_pkg::*;

	logic                   inflight_q;	// sram answers for inflight_pc_q this cycle
	logic [`FETCH_XLEN-1:0] inflight_pc_q;
	logic                   held_q;		// word parked in hold_data_q
	logic [`FETCH_XLEN-1:0] hold_data_q;
	logic [`FETCH_XLEN-1:0] word;
	logic                   adel;
	fetch_item_t            item;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			inflight_q <= 1'b0;
			held_q     <= 1'b0;
		end else if (flush_i) begin
			// drop whatever was fetched before the flush
			inflight_q <= 1'b0;
			held_q     <= 1'b0;
		end else if (stall_i) begin
			if (inflight_q)
				held_q <= 1'b1;
		end else begin
			inflight_q <= issue_i;
			held_q     <= 1'b0;
		end
	end

	// address and parked word
	always_ff @(posedge clk) begin
		if (!stall_i)
			inflight_pc_q <= issue_pc_i;

		// sram output is only good on the first stalled cycle
		if (stall_i && inflight_q && !held_q)
			hold_data_q <= inst_sram_rdata_i;
	end

	assign word = held_q ? hold_data_q : inst_sram_rdata_i;
	assign adel = |inflight_pc_q[1:0];	// not word aligned

	always_comb begin
		item.pc     = inflight_pc_q;
		item.inst   = adel ? '0 : word;	// bad address fetches nothing
		item.exc    = adel ? EXC_ADEL : EXC_NONE;
		item.inslot = 1'b0;		// filled in by jump_decode
	end

	assign item_o.valid = inflight_q;
	assign item_o.item  = item;

endmodule

`default_nettype wire

//--- design/jump_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module jump_decode (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  logic                   flush_i,
	fetch_item_if.sink             item_i,
	output logic                   jump_o,		// to pc_gen
	output logic [`FETCH_XLEN-1:0] jump_pc_o,
	output logic                   id_valid_o,
	output logic [`FETCH_XLEN-1:0] id_pc_o,
	output logic [`FETCH_XLEN-1:0] id_inst_o,
	output fetch_pkg::fetch_exc_e  id_exc_o,
	output logic                   id_inslot_o
);
	import fetch_pkg::*;

	localparam logic [`FETCH_XLEN-1:0] PC_STEP = 4;

	fetch_op_e              op;
	logic                   is_jump;
	logic                   accept;
	logic [`FETCH_XLEN-1:0] slot_pc;	// delay slot address
	logic                   slot_q;		// next accepted item is a delay slot
	logic                   valid_q;
	fetch_item_t            id_q;
	fetch_item_t            next_item;

	assign op = fetch_op_e'(item_i.item.inst[31:26]);

	always_comb begin
		case (op)
			OP_J, OP_JAL: is_jump = item_i.valid && (item_i.item.exc == EXC_NONE);
			default:      is_jump = 1'b0;	// jr/jalr need the register file
		endcase
	end

	assign accept = item_i.valid & ~stall_i;

	// target lives in the 256 MB region of the delay slot
	assign slot_pc   = item_i.item.pc + PC_STEP;
	assign jump_o    = is_jump & ~stall_i;
	assign jump_pc_o = {slot_pc[31:28], item_i.item.inst[25:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_q  <= 1'b0;
			valid_q <= 1'b0;
		end else if (flush_i) begin
			slot_q  <= 1'b0;	// pending redirect is cancelled
			valid_q <= 1'b0;
		end else if (!stall_i) begin
			valid_q <= item_i.valid;
			if (accept)
				slot_q <= is_jump;
		end
	end

	always_comb begin
		next_item        = item_i.item;
		next_item.inslot = slot_q;
	end

	always_ff @(posedge clk) begin
		if (accept)
			id_q <= next_item;
	end

	assign id_valid_o  = valid_q;
	assign id_pc_o     = id_q.pc;
	assign id_inst_o   = id_q.inst;
	assign id_exc_o    = id_q.exc;
	assign id_inslot_o = id_q.inslot;

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_top (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  logic                   flush_i,
	input  logic [`FETCH_XLEN-1:0] flush_pc_i,
	input  logic [`FETCH_XLEN-1:0] inst_sram_rdata_i,
	output logic                   inst_sram_en_o,
	output logic [`FETCH_XLEN-1:0] inst_sram_addr_o,
	output logic                   id_valid_o,
	output logic [`FETCH_XLEN-1:0] id_pc_o,
	output logic [`FETCH_XLEN-1:0] id_inst_o,
	output fetch_pkg::fetch_exc_e  id_exc_o,
	output logic                   id_inslot_o
);

	logic                   issue;
	logic [`FETCH_XLEN-1:0] issue_pc;
	logic                   jump;		// redirect back from decode
	logic [`FETCH_XLEN-1:0] jump_pc;

	fetch_item_if if_item ();	// if_stage to jump_decode

	pc_gen u_pc_gen (
		.clk              (clk),
		.rst_i            (rst_i),
		.stall_i          (stall_i),
		.flush_i          (flush_i),
		.flush_pc_i       (flush_pc_i),
		.jump_i           (jump),
		.jump_pc_i        (jump_pc),
		.inst_sram_en_o   (inst_sram_en_o),
		.inst_sram_addr_o (inst_sram_addr_o),
		.issue_o          (issue),
		.issue_pc_o       (issue_pc)
	);

	if_stage u_if_stage (
		.clk               (clk),
		.rst_i             (rst_i),
		.stall_i           (stall_i),
		.flush_i           (flush_i),
		.issue_i           (issue),
		.issue_pc_i        (issue_pc),
		.inst_sram_rdata_i (inst_sram_rdata_i),
		.item_o            (if_item.source)
	);

	jump_decode u_jump_decode (
		.clk         (clk),
		.rst_i       (rst_i),
		.stall_i     (stall_i),
		.flush_i     (flush_i),
		.item_i      (if_item.sink),
		.jump_o      (jump),
		.jump_pc_o   (jump_pc),
		.id_valid_o  (id_valid_o),
		.id_pc_o     (id_pc_o),
		.id_inst_o   (id_inst_o),
		.id_exc_o    (id_exc_o),
		.id_inslot_o (id_inslot_o)
	);

endmodule

`default_nettype wire

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int          RESET_CYCLES   = 5;
	localparam int          STIM_CYCLES    = 3000;
	localparam int          TIMEOUT_CYCLES = STIM_CYCLES + 1000;
	localparam int          LIVE_LIMIT     = 64;
	localparam int          WIN_WORDS      = 1024;	// 4 KB window at the reset vector
	localparam logic [31:0] BASE           = `FETCH_RESET_VECTOR;
	localparam logic [5:0]  OPC_J          = 6'h02;
	localparam logic [5:0]  OPC_JAL        = 6'h03;

	logic        clk;
	logic        rst_i;
	logic        stall_i;
	logic        flush_i;
	logic [31:0] flush_pc_i;
	logic [31:0] inst_sram_rdata_i = 32'd0;
	logic        inst_sram_en_o;
	logic [31:0] inst_sram_addr_o;
	logic        id_valid_o;
	logic [31:0] id_pc_o;
	logic [31:0] id_inst_o;
	fetch_exc_e  id_exc_o;
	logic        id_inslot_o;

	integer      seed;
	logic [31:0] rom [WIN_WORDS];
	int          cycles = 0;
	int          err_count = 0;
	int          n_items = 0;
	int          n_slots = 0;
	int          n_adel = 0;
	int          n_flush = 0;
	int          idle = 0;

	// reference model state
	logic [31:0] exp_pc = BASE;
	logic        pend = 1'b0;		// next item is a delay slot
	logic [31:0] pend_tgt = 32'd0;

	// inputs that applied at the last rising edge
	logic        prev_rst = 1'b1;
	logic        prev_stall = 1'b0;
	logic        prev_flush = 1'b0;
	logic [31:0] prev_flush_pc = 32'd0;

	// outputs seen at the last sample
	logic        last_valid = 1'b0;
	logic [31:0] last_pc = 32'd0;
	logic [31:0] last_inst = 32'd0;
	logic [31:0] last_exc = 32'd0;
	logic        last_inslot = 1'b0;

	logic        req_en = 1'b0;
	logic [31:0] req_addr = 32'd0;

	fetch_top dut (
		.clk               (clk),
		.rst_i             (rst_i),
		.stall_i           (stall_i),
		.flush_i           (flush_i),
		.flush_pc_i        (flush_pc_i),
		.inst_sram_rdata_i (inst_sram_rdata_i),
		.inst_sram_en_o    (inst_sram_en_o),
		.inst_sram_addr_o  (inst_sram_addr_o),
		.id_valid_o        (id_valid_o),
		.id_pc_o           (id_pc_o),
		.id_inst_o         (id_inst_o),
		.id_exc_o          (id_exc_o),
		.id_inslot_o       (id_inslot_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic is_jump_op(input logic [31:0] word);
		return (word[31:26] == OPC_J) || (word[31:26] == OPC_JAL);
	endfunction

	// table inside the window, hashed address outside it (never a jump there)
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] a;
		logic [31:0] off;
		a   = {addr[31:2], 2'b00};
		off = a - BASE;
		if (off < 32'(WIN_WORDS * 4))
			return rom[off[11:2]];
		return {6'h23, a[31:6] ^ a[27:2]};
	endfunction

	task automatic fill_rom();
		logic [31:0] r;
		logic [31:0] tgt;
		for (int i = 0; i < WIN_WORDS; i++) begin
			r = $random(seed);
			if (r[2:0] == 3'b000) begin
				tgt    = BASE + {20'd0, r[13:4], 2'b00};	// lands inside the window
				rom[i] = {(r[3] ? OPC_JAL : OPC_J), tgt[27:2]};
			end else if (is_jump_op(r)) begin
				rom[i] = r ^ 32'h8000_0000;	// stray jump becomes a load
			end else begin
				rom[i] = r;
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic drive_random();
		logic [31:0] r;
		logic [1:0]  low;
		r       = $random(seed);
		stall_i = (r[1:0] == 2'b00);
		r       = $random(seed);
		flush_i = (r[4:0] == 5'd0);
		r       = $random(seed);
		low     = 2'b00;
		if (r[15:14] == 2'b00)	// one flush address in four is misaligned
			low = (r[13:12] == 2'b00) ? 2'b01 : r[13:12];
		flush_pc_i = BASE + {20'd0, r[11:2], low};
	endtask

	// predict one item, compare, then step the model
	task automatic check_item();
		logic        adel;
		logic [31:0] exp_inst;
		logic [31:0] nxt;
		logic [31:0] slot;
		adel     = |exp_pc[1:0];
		exp_inst = adel ? 32'd0 : mem_word(exp_pc);
		check_value("id_pc_o", id_pc_o, exp_pc);
		check_value("id_inst_o", id_inst_o, exp_inst);
		check_value("id_exc_o", 32'(id_exc_o), adel ? 32'(EXC_ADEL) : 32'(EXC_NONE));
		check_value("id_inslot_o", 32'(id_inslot_o), 32'(pend));
		n_items++;
		if (pend)
			n_slots++;
		if (adel)
			n_adel++;
		nxt = pend ? pend_tgt : exp_pc + 32'd4;
		if (!adel && is_jump_op(exp_inst)) begin
			slot     = exp_pc + 32'd4;
			pend_tgt = {slot[31:28], exp_inst[25:0], 2'b00};
			pend     = 1'b1;
		end else begin
			pend = 1'b0;
		end
		exp_pc = nxt;
	endtask

	// instruction sram, one cycle read, inverted word when idle
	always @(negedge clk) begin
		req_en   <= inst_sram_en_o;
		req_addr <= inst_sram_addr_o;
	end

	always @(posedge clk) begin
		#10;
		if (req_en)
			inst_sram_rdata_i = mem_word(req_addr);
		else
			inst_sram_rdata_i = ~mem_word(req_addr);
	end

	// monitor samples mid cycle, away from both edges
	always @(negedge clk) begin
		if (prev_rst) begin
			check_value("id_valid_o", 32'(id_valid_o), 32'd0);
			check_value("inst_sram_en_o", 32'(inst_sram_en_o), 32'd0);
			exp_pc = BASE;
			pend   = 1'b0;
			idle   = 0;
		end else if (prev_flush) begin
			check_value("id_valid_o", 32'(id_valid_o), 32'd0);
			exp_pc = prev_flush_pc;	// pending redirect is dropped too
			pend   = 1'b0;
			idle   = 0;
			n_flush++;
		end else if (prev_stall) begin
			check_value("id_valid_o", 32'(id_valid_o), 32'(last_valid));
			if (last_valid) begin
				check_value("id_pc_o", id_pc_o, last_pc);
				check_value("id_inst_o", id_inst_o, last_inst);
				check_value("id_exc_o", 32'(id_exc_o), last_exc);
				check_value("id_inslot_o", 32'(id_inslot_o), 32'(last_inslot));
			end
		end else if (id_valid_o) begin
			check_item();
			idle = 0;
		end else begin
			idle++;
			if (idle > LIVE_LIMIT) begin
				$display("no item reached id_* within %0d cycles, at %0t", LIVE_LIMIT,
					$time);
				err_count++;
				idle = 0;
			end
		end

		if (!rst_i && (stall_i || flush_i))
			check_value("inst_sram_en_o", 32'(inst_sram_en_o), 32'd0);

		last_valid    = id_valid_o;
		last_pc       = id_pc_o;
		last_inst     = id_inst_o;
		last_exc      = 32'(id_exc_o);
		last_inslot   = id_inslot_o;
		prev_rst      = rst_i;
		prev_stall    = stall_i;
		prev_flush    = flush_i;
		prev_flush_pc = flush_pc_i;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, stimulus never finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		seed       = 32'hdee2_d036;
		rst_i      = 1'b1;
		stall_i    = 1'b0;
		flush_i    = 1'b0;
		flush_pc_i = 32'd0;
		fill_rom();

		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		rst_i = 1'b0;

		repeat (STIM_CYCLES) begin
			drive_random();
			@(posedge clk);
			#10;
		end
		stall_i = 1'b0;
		flush_i = 1'b0;

		if (n_items == 0) begin
			$display("no item was ever delivered on id_*");
			err_count++;
		end
		if (n_slots == 0 || n_adel == 0 || n_flush == 0) begin
			$display("stimulus missed a case: slots %0d, address errors %0d, flushes %0d",
				n_slots, n_adel, n_flush);
			err_count++;
		end

		$display("items %0d, delay slots %0d, address errors %0d, flushes %0d, errors %0d",
			n_items, n_slots, n_adel, n_flush, err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_top.f
+incdir+.
design/fetch_pkg.sv
design/fetch_item_if.sv
design/pc_gen.sv
design/if_stage.sv
design/jump_decode.sv
design/fetch_top.sv
dv/fetch_tb.sv

//--- Makefile
# Verilator build for the fetch front end

VERILATOR  ?= verilator
FILELIST   ?= fetch_top.f
TOP        ?= fetch_tb
RTL_TOP    ?= fetch_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then with the testbench on top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
